/* src/lab_pkg.sv */
// Shared constants of the microphone level meter: sample, level, I2S frame and peak states
`default_nettype none

package lab_pkg;

    //----------------------------------------
    // Microphone sample and level
    //----------------------------------------

    localparam int w_sample  = 24;  // INMP441 word width
    localparam int w_level   = 8;   // Level and peak width
    localparam int level_lsb = 15;  // Lowest magnitude bit shown as level

    //----------------------------------------
    // I2S frame
    //----------------------------------------

    localparam int slot_bits = 32;  // sck periods per channel slot

    //----------------------------------------
    // Peak state encoding
    //----------------------------------------

    localparam logic [1:0] peak_track = 2'd0;  // Follow the loudest sample
    localparam logic [1:0] peak_hold  = 2'd1;  // Freeze while the hold key is down
    localparam logic [1:0] peak_clear = 2'd2;  // One cycle, zeroes the peak

endpackage

`default_nettype wire

/* src/i2s_clock_gen.sv */
// I2S timing generator: divides clk into sck, counts the 64 bit slots and drives word select
`timescale 1ns/100ps
`default_nettype none

module i2s_clock_gen #(
    parameter sck_div = 8
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    output logic                                 sck,
    output logic                                 ws,
    output logic                                 rise,
    output logic [$clog2(lab_pkg::slot_bits)-1:0] bit_index
);

    import lab_pkg::*;

    localparam w_div  = (sck_div > 1) ? $clog2(sck_div) : 1;
    localparam w_slot = $clog2(2 * slot_bits);

    logic [w_div-1:0]  div_cnt;
    logic [w_slot-1:0] slot_cnt;
    logic [w_slot-1:0] slot_next;
    logic              half_end;

    assign half_end  = (div_cnt == w_div'(sck_div - 1));  // Last clk of an sck half-period
    assign slot_next = slot_cnt + 1'b1;
    assign bit_index = slot_cnt[w_slot-2:0];              // Position inside the slot

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            rise     <= 1'b0;
            slot_cnt <= '1;    // First falling edge starts slot 0
            ws       <= 1'b1;
        end else begin
            rise <= half_end && !sck;  // High together with sck going high
            if (half_end) begin
                div_cnt <= '0;
                sck     <= !sck;
                if (sck) begin  // Falling edge
                    slot_cnt <= slot_next;
                    ws       <= slot_next[w_slot-1];  // Right slot is the upper half
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/inmp441_mic_i2s_receiver.sv */
// INMP441 receiver: shifts in the left-channel word and strobes it when the LSB is in
`timescale 1ns/100ps
`default_nettype none

module inmp441_mic_i2s_receiver #(
    parameter sck_div = 8
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                sd,
    output logic                                sck,
    output logic                                ws,
    output logic signed [lab_pkg::w_sample-1:0] value,
    output logic                                value_valid
);

    import lab_pkg::*;

    logic                         rise;
    logic [$clog2(slot_bits)-1:0] bit_index;
    logic [w_sample-2:0]          shift_reg;
    logic                         capture;
    logic                         last_bit;

    i2s_clock_gen #(
        .sck_div   ( sck_div   )
    ) u_i2s_clock_gen (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .sck       ( sck       ),
        .ws        ( ws        ),
        .rise      ( rise      ),
        .bit_index ( bit_index )
    );

    // Bit 0 of the slot is the I2S delay bit, the word follows MSB first
    assign capture  = rise && !ws && (bit_index != '0) && (bit_index <= w_sample);
    assign last_bit = capture && (bit_index == w_sample);

    always_ff @(posedge clk) begin
        if (capture) begin
            shift_reg <= {shift_reg[w_sample-3:0], sd};
        end
        if (last_bit) begin
            value <= {shift_reg, sd};  // Held until the next left slot ends
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value_valid <= 1'b0;
        end else begin
            value_valid <= last_bit;
        end
    end

endmodule

`default_nettype wire

/* src/tick_timer.sv */
// Cascaded prescaler giving the digit refresh tick and the slower peak decay tick
`timescale 1ns/100ps
`default_nettype none

module tick_timer #(
    parameter refresh_div = 50000,
    parameter decay_div   = 20
) (
    input  logic clk,
    input  logic arst_n,
    output logic refresh_tick,
    output logic decay_tick
);

    localparam w_pre = (refresh_div > 1) ? $clog2(refresh_div) : 1;
    localparam w_dec = (decay_div > 1) ? $clog2(decay_div) : 1;

    logic [w_pre-1:0] pre_cnt;
    logic [w_dec-1:0] dec_cnt;
    logic             pre_end;
    logic             dec_end;

    assign pre_end = (pre_cnt == w_pre'(refresh_div - 1));
    assign dec_end = (dec_cnt == w_dec'(decay_div - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt      <= '0;
            dec_cnt      <= '0;
            refresh_tick <= 1'b0;
            decay_tick   <= 1'b0;
        end else begin
            refresh_tick <= pre_end;
            decay_tick   <= pre_end && dec_end;  // Every decay_div refresh ticks
            if (pre_end) begin
                pre_cnt <= '0;
                dec_cnt <= dec_end ? '0 : dec_cnt + 1'b1;
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/peak_hold_fsm.sv */
// Peak meter FSM: sample magnitude to level, peak with max, decay, hold and clear
`timescale 1ns/100ps
`default_nettype none

module peak_hold_fsm (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic signed [lab_pkg::w_sample-1:0] sample,
    input  logic                                sample_valid,
    input  logic                                decay_tick,
    input  logic                                hold_key,
    input  logic                                clear_key,
    output logic        [lab_pkg::w_level-1:0]  level,
    output logic        [lab_pkg::w_level-1:0]  peak
);

    import lab_pkg::*;

    logic [1:0]          state;
    logic [1:0]          state_next;
    logic                clear_key_d;
    logic [w_sample-1:0] mag;
    logic [w_level-1:0]  level_in;

    //----------------------------------------
    // Saturated magnitude
    //----------------------------------------

    // Most negative sample gives 2**23 unsigned, which saturates below
    assign mag      = sample[w_sample-1] ? unsigned'(-sample) : unsigned'(sample);
    assign level_in = (|mag[w_sample-1:level_lsb+w_level]) ? '1
                                                          : mag[level_lsb+w_level-1:level_lsb];

    //----------------------------------------
    // State machine
    //----------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            peak_clear: state_next = peak_track;
            default: begin
                if (clear_key && !clear_key_d) begin  // Press, not level
                    state_next = peak_clear;
                end else if (hold_key) begin
                    state_next = peak_hold;
                end else begin
                    state_next = peak_track;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= peak_track;
            clear_key_d <= 1'b0;
            level       <= '0;
            peak        <= '0;
        end else begin
            state       <= state_next;
            clear_key_d <= clear_key;
            if (sample_valid) begin
                level <= level_in;
            end
            case (state)
                peak_clear: peak <= '0;
                peak_track: begin
                    if (sample_valid && level_in > peak) begin
                        peak <= level_in;
                    end else if (decay_tick && peak != '0) begin
                        peak <= peak - 1'b1;
                    end
                end
                default: peak <= peak;  // Frozen in hold
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/seven_segment_display.sv */
// Display driver: digit scan, hex font for peak and level nibbles, LED bar graph of the peak
`timescale 1ns/100ps
`default_nettype none

module seven_segment_display #(
    parameter w_led   = 12,
    parameter w_digit = 7
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        refresh_tick,
    input  logic [lab_pkg::w_level-1:0] peak,
    input  logic [lab_pkg::w_level-1:0] level,
    output logic [w_led-1:0]            led,
    output logic [7:0]                  abcdefgh,
    output logic [w_digit-1:0]          digit
);

    import lab_pkg::*;

    logic [3:0] nibble;
    logic       blank;

    function automatic logic [7:0] hex_font(input logic [3:0] n);
        case (n)  // Segments a..g, dot off
            4'h0: hex_font = 8'b1111_1100;
            4'h1: hex_font = 8'b0110_0000;
            4'h2: hex_font = 8'b1101_1010;
            4'h3: hex_font = 8'b1111_0010;
            4'h4: hex_font = 8'b0110_0110;
            4'h5: hex_font = 8'b1011_0110;
            4'h6: hex_font = 8'b1011_1110;
            4'h7: hex_font = 8'b1110_0000;
            4'h8: hex_font = 8'b1111_1110;
            4'h9: hex_font = 8'b1111_0110;
            4'ha: hex_font = 8'b1110_1110;
            4'hb: hex_font = 8'b0011_1110;
            4'hc: hex_font = 8'b1001_1100;
            4'hd: hex_font = 8'b0111_1010;
            4'he: hex_font = 8'b1001_1110;
            default: hex_font = 8'b1000_1110;
        endcase
    endfunction

    //----------------------------------------
    // Digit scan
    //----------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            digit <= '0;  // All digits dark until the first tick
        end else if (refresh_tick) begin
            digit <= (digit == '0) ? w_digit'(1) : {digit[w_digit-2:0], digit[w_digit-1]};
        end
    end

    always_comb begin
        nibble = 4'h0;
        blank  = 1'b1;
        for (int i = 0; i < w_digit; i++) begin
            if (digit[i] && i < 4) begin
                blank = 1'b0;
                case (i)
                    0:       nibble = peak[3:0];
                    1:       nibble = peak[7:4];
                    2:       nibble = level[3:0];
                    default: nibble = level[7:4];
                endcase
            end
        end
    end

    assign abcdefgh = blank ? 8'h00 : hex_font(nibble);

    //----------------------------------------
    // LED bar
    //----------------------------------------

    always_comb begin
        for (int i = 0; i < w_led; i++) begin
            led[i] = int'(peak[w_level-1 -: 4]) > i;  // Thermometer of the upper nibble
        end
    end

endmodule

`default_nettype wire

/* src/top.sv */
// Microphone level meter lab: tick timer, peak FSM and display
`timescale 1ns/100ps
`default_nettype none

module top #(
    parameter w_key       = 3,
    parameter w_led       = 12,
    parameter w_digit     = 7,
    parameter refresh_div = 50000,
    parameter decay_div   = 20
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic        [w_key-1:0]             key,
    input  logic signed [lab_pkg::w_sample-1:0] sample,
    input  logic                                sample_valid,
    output logic        [w_led-1:0]             led,
    output logic        [7:0]                   abcdefgh,
    output logic        [w_digit-1:0]           digit
);

    import lab_pkg::*;

    logic               refresh_tick;
    logic               decay_tick;
    logic [w_level-1:0] level;
    logic [w_level-1:0] peak;

    tick_timer #(
        .refresh_div  ( refresh_div  ),
        .decay_div    ( decay_div    )
    ) u_tick_timer (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .refresh_tick ( refresh_tick ),
        .decay_tick   ( decay_tick   )
    );

    peak_hold_fsm u_peak_hold_fsm (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .decay_tick   ( decay_tick   ),
        .hold_key     ( key[0]       ),  // Hold while pressed
        .clear_key    ( key[1]       ),  // Clear on press
        .level        ( level        ),
        .peak         ( peak         )
    );

    seven_segment_display #(
        .w_led        ( w_led        ),
        .w_digit      ( w_digit      )
    ) u_seven_segment_display (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .refresh_tick ( refresh_tick ),
        .peak         ( peak         ),
        .level        ( level        ),
        .led          ( led          ),
        .abcdefgh     ( abcdefgh     ),
        .digit        ( digit        )
    );

endmodule

`default_nettype wire

/* src/board_specific_top.sv */
// Board wrapper: active-low pins, reset key, INMP441 wiring on GPIO and the dead rightmost digit
`timescale 1ns/100ps
`default_nettype none

module board_specific_top #(
    parameter clk_mhz     = 50,
    parameter w_key       = 3,
    parameter w_led       = 12,
    parameter w_digit     = 8,
    parameter sck_div     = 8,
    parameter refresh_div = clk_mhz * 1000,  // 1 kHz scan
    parameter decay_div   = 20
) (
    input  wire               CLK,
    input  wire [w_key:0]     KEY_N,       // Top key is the reset
    output wire [w_led-1:0]   LED_N,
    output wire [7:0]         ABCDEFGH_N,
    output wire [w_digit-1:0] DIGIT_N,
    inout  wire [5:0]         GPIO
);

    import lab_pkg::*;

    localparam w_top_digit = w_digit - 1;  // Rightmost digit does not work

    logic                       arst_n;
    logic        [w_led-1:0]    led;
    logic        [7:0]          abcdefgh;
    logic        [w_top_digit-1:0] top_digit;
    logic                       mic_sck;
    logic                       mic_ws;
    logic signed [w_sample-1:0] mic_value;
    logic                       mic_valid;

    assign arst_n = KEY_N[w_key];  // Key 3, low while pressed

    //----------------------------------------
    // Microphone
    //----------------------------------------

    inmp441_mic_i2s_receiver #(
        .sck_div     ( sck_div   )
    ) u_inmp441_mic_i2s_receiver (
        .clk         ( CLK       ),
        .arst_n      ( arst_n    ),
        .sd          ( GPIO[0]   ),
        .sck         ( mic_sck   ),
        .ws          ( mic_ws    ),
        .value       ( mic_value ),
        .value_valid ( mic_valid )
    );

    assign GPIO[1] = mic_sck;
    assign GPIO[2] = 1'b1;    // Mic VDD
    assign GPIO[3] = mic_ws;
    assign GPIO[4] = 1'b0;    // Mic GND
    assign GPIO[5] = 1'b0;    // L/R low selects the left slot

    //----------------------------------------
    // Lab
    //----------------------------------------

    top #(
        .w_key        ( w_key            ),
        .w_led        ( w_led            ),
        .w_digit      ( w_top_digit      ),
        .refresh_div  ( refresh_div      ),
        .decay_div    ( decay_div        )
    ) u_top (
        .clk          ( CLK              ),
        .arst_n       ( arst_n           ),
        .key          ( ~KEY_N[w_key-1:0] ),
        .sample       ( mic_value        ),
        .sample_valid ( mic_valid        ),
        .led          ( led              ),
        .abcdefgh     ( abcdefgh         ),
        .digit        ( top_digit        )
    );

    assign LED_N      = ~led;
    assign ABCDEFGH_N = ~abcdefgh;
    assign DIGIT_N    = ~{top_digit, 1'b0};  // Board digit 0 stays dark

endmodule

`default_nettype wire

/* sim/board_specific_top_chk.sv */
// Assertions on the board wrapper: digit select, I2S word select timing and LED bar shape
`timescale 1ns/100ps
`default_nettype none

module board_specific_top_chk #(
    parameter w_key   = 3,
    parameter w_led   = 12,
    parameter w_digit = 8
) (
    input wire               CLK,
    input wire [w_key:0]     KEY_N,
    input wire [w_led-1:0]   LED_N,
    input wire [w_digit-1:0] DIGIT_N,
    input wire [5:0]         GPIO
);

    logic [w_led-1:0] led;

    assign led = ~LED_N;

    a_digit_one_hot: assert property (@(posedge CLK) disable iff (!KEY_N[w_key])
        $countones(~DIGIT_N) <= 1 && DIGIT_N[0])
        else $error("more than one digit on, or the dead digit driven");

    a_ws_on_sck_fall: assert property (@(posedge CLK) disable iff (!KEY_N[w_key])
        $changed(GPIO[3]) |-> $fell(GPIO[1]))
        else $error("ws changed away from an sck falling edge");

    a_led_thermometer: assert property (@(posedge CLK)
        (led & (led + 1'b1)) == '0)
        else $error("LED bar is not a thermometer code");

endmodule

bind board_specific_top board_specific_top_chk #(
    .w_key   ( w_key   ),
    .w_led   ( w_led   ),
    .w_digit ( w_digit )
) u_board_specific_top_chk (.*);

`default_nettype wire

/* sim/tb_board_specific_top.sv */
// Testbench for the microphone level meter: I2S microphone model, vector sequence and checks
`timescale 1ns/100ps
`default_nettype none

module tb_board_specific_top;

    localparam w_led        = 12;
    localparam w_digit      = 8;
    localparam sck_div      = 2;
    localparam refresh_div  = 16;
    localparam decay_div    = 512;  // Long decay keeps peaks still during vectors
    localparam frame_cycles = 64 * 2 * sck_div;

    // Standard hex font, segments a..g, dot off
    localparam logic [7:0] font [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    logic               CLK;
    logic [3:0]         KEY_N;
    wire  [w_led-1:0]   LED_N;
    wire  [7:0]         ABCDEFGH_N;
    wire  [w_digit-1:0] DIGIT_N;
    wire  [5:0]         GPIO;

    logic [35:0] vectors [0:15];  // Sample, keys, expected peak
    int          vec_count;
    logic        loaded;
    logic [23:0] cur_sample;
    logic [23:0] frame_word;
    logic        mic_sd;
    logic        prev_ws;
    logic [31:0] rng;
    int          slot;
    int          frame_count;
    int          lsb_count;

    assign GPIO[0] = mic_sd;

    board_specific_top #(
        .w_digit     ( w_digit     ),
        .sck_div     ( sck_div     ),
        .refresh_div ( refresh_div ),
        .decay_div   ( decay_div   )
    ) u_board_specific_top (
        .CLK        ( CLK        ),
        .KEY_N      ( KEY_N      ),
        .LED_N      ( LED_N      ),
        .ABCDEFGH_N ( ABCDEFGH_N ),
        .DIGIT_N    ( DIGIT_N    ),
        .GPIO       ( GPIO       )
    );

    always #10 CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] sample_level(input logic [23:0] s);
        logic [24:0] mag;
        mag = s[23] ? 25'(-$signed({s[23], s})) : {1'b0, s};  // Magnitude of the sample
        return (mag >> 15) > 255 ? 8'hff : 8'(mag >> 15);
    endfunction

    function automatic logic [w_led-1:0] led_bar(input logic [7:0] peak);
        logic [w_led-1:0] bar;
        for (int i = 0; i < w_led; i++) begin
            bar[i] = peak[7:4] > i;
        end
        return bar;
    endfunction

    //----------------------------------------
    // I2S microphone model
    //----------------------------------------

    always @(negedge GPIO[1]) begin
        #1;
        if (prev_ws && !GPIO[3]) begin  // Left slot starts
            slot       = 0;
            frame_word = cur_sample;
            frame_count++;
        end else begin
            slot++;
        end
        prev_ws = GPIO[3];
        if (!GPIO[3] && slot >= 1 && slot <= 24) begin
            mic_sd = frame_word[24-slot];  // MSB first
        end else begin
            rng    = xorshift32(rng);
            mic_sd = rng[0];
        end
    end

    always @(posedge GPIO[1]) begin
        if (!GPIO[3] && slot == 24) begin
            lsb_count++;
        end
    end

    //----------------------------------------
    // Checks
    //----------------------------------------

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_led(input string name, input logic [w_led-1:0] exp,
                             input logic [w_led-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_segments(input string name, input logic [7:0] exp,
                                  input logic [7:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_digits(input string name, input logic [w_digit-1:0] exp,
                                input logic [w_digit-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_pin(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s expected %b, got %b",
                                    $time, name, exp, act));
        end
    endtask

    task automatic drive_inputs(input logic [23:0] s, input logic [2:0] keys);
        @(posedge CLK);
        #2;
        cur_sample = s;
        KEY_N[2:0] = ~keys;
    endtask

    task automatic wait_digit_on(input int idx);
        do begin
            @(posedge CLK);
            #5;
        end while (DIGIT_N[idx] !== 1'b0);
    endtask

    initial begin
        longint limit;
        wait (loaded === 1'b1);
        limit = longint'(vec_count) * frame_cycles * 2 + 256 * refresh_div * decay_div + 8192;
        repeat (limit) @(posedge CLK);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        logic [7:0]       model_peak;
        logic [7:0]       model_level;
        logic [7:0]       file_peak;
        logic [2:0]       keys;
        logic [w_led-1:0] led_before;
        logic             prev_clear;
        logic             hi_zero;
        logic             done;
        int               n;
        int               bar;
        int               prev_bar;
        CLK         = 1'b0;
        KEY_N       = 4'b0111;  // Reset pressed, lab keys released
        cur_sample  = '0;
        mic_sd      = 1'b0;
        prev_ws     = 1'b1;
        rng         = 32'haebb;
        slot        = 0;
        frame_count = 0;
        lsb_count   = 0;
        vec_count   = 0;
        loaded      = 1'b0;
        for (int i = 0; i < 16; i++) begin
            vectors[i] = {24'(i), 4'hf, 8'(i)};  // Key nibble f marks an unused row
        end
        $readmemh("sim/mic_input.txt", vectors);
        while (vec_count < 16 && vectors[vec_count][11] == 1'b0) begin
            vec_count++;
        end
        loaded = 1'b1;
        if (vec_count == 0) begin
            stop_on_error("No vectors were read from the data file");
        end
        repeat (16) @(posedge CLK);
        #2;
        check_led("LED_N", '1, LED_N);
        check_digits("DIGIT_N", '1, DIGIT_N);
        check_pin("GPIO[1]", 1'b0, GPIO[1]);  // sck idles low
        check_pin("GPIO[2]", 1'b1, GPIO[2]);
        check_pin("GPIO[3]", 1'b1, GPIO[3]);
        check_pin("GPIO[4]", 1'b0, GPIO[4]);
        check_pin("GPIO[5]", 1'b0, GPIO[5]);
        KEY_N[3] = 1'b1;

        // Peak digits show 00 after the first refresh ticks
        wait_digit_on(1);
        check_segments("ABCDEFGH_N", ~font[0], ABCDEFGH_N);
        wait_digit_on(2);
        check_segments("ABCDEFGH_N", ~font[0], ABCDEFGH_N);

        model_peak  = '0;
        model_level = '0;
        prev_clear  = 1'b0;
        for (int v = 0; v < vec_count; v++) begin
            keys        = vectors[v][10:8];
            file_peak   = vectors[v][7:0];
            model_level = sample_level(vectors[v][35:12]);
            if (keys[1] && !prev_clear) begin
                model_peak = '0;
            end
            led_before = led_bar(model_peak);  // Bar until the new sample lands
            if (!keys[0] && model_level > model_peak) begin
                model_peak = model_level;
            end
            prev_clear = keys[1];
            if (model_peak != file_peak) begin
                stop_on_error($sformatf("Vector %0d in the data file has a wrong peak", v));
            end
            drive_inputs(vectors[v][35:12], keys);
            n = frame_count;
            wait (frame_count > n);  // Next left slot carries the new sample
            n = lsb_count;
            wait (lsb_count > n);
            @(posedge CLK);
            #5;
            check_led("LED_N", ~led_before, LED_N);
            @(posedge CLK);
            #5;
            check_led("LED_N", ~led_bar(model_peak), LED_N);
        end

        // Scan two rotations and check each lab digit
        repeat (2 * (w_digit - 1) * refresh_div) begin
            @(posedge CLK);
            #5;
            for (int i = 0; i < w_digit - 1; i++) begin
                if (!DIGIT_N[i+1]) begin
                    case (i)
                        0: check_segments("ABCDEFGH_N", ~font[model_peak[3:0]], ABCDEFGH_N);
                        1: check_segments("ABCDEFGH_N", ~font[model_peak[7:4]], ABCDEFGH_N);
                        2: check_segments("ABCDEFGH_N", ~font[model_level[3:0]], ABCDEFGH_N);
                        3: check_segments("ABCDEFGH_N", ~font[model_level[7:4]], ABCDEFGH_N);
                        default: check_segments("ABCDEFGH_N", 8'hff, ABCDEFGH_N);
                    endcase
                end
            end
        end

        // Silence, the peak decays to 0
        drive_inputs(24'h0, 3'b000);
        prev_bar = $countones(~LED_N);
        hi_zero  = 1'b0;
        done     = 1'b0;
        while (!done) begin
            @(posedge CLK);
            #5;
            bar = $countones(~LED_N);
            if (bar > prev_bar) begin
                stop_on_error("LED bar rose while the peak was decaying");
            end
            prev_bar = bar;
            if (!DIGIT_N[2]) begin
                hi_zero = (ABCDEFGH_N == ~font[0]);
            end
            if (!DIGIT_N[1] && hi_zero && ABCDEFGH_N == ~font[0]) begin
                done = 1'b1;
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/mic_input.txt */
// Columns: sample (24 bit) _ keys (bit 0 hold, bit 1 clear) _ expected peak
// Level is the sample magnitude bits 22..15, saturated at ff
008000_0_01
0a0000_0_14
050000_0_14
7fffff_0_ff
100000_2_20
800000_0_ff
080000_2_10
f80000_0_10
300000_1_10
400000_1_10
300000_0_60
fe0000_2_04
018000_0_04
600000_0_c0

/* sources.f */
src/lab_pkg.sv
src/i2s_clock_gen.sv
src/inmp441_mic_i2s_receiver.sv
src/tick_timer.sv
src/peak_hold_fsm.sv
src/seven_segment_display.sv
src/top.sv
src/board_specific_top.sv
sim/board_specific_top_chk.sv
sim/tb_board_specific_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_board_specific_top
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat sources.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sources.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f sources.f

run: $(BIN) sim/mic_input.txt
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
